//--- verilog/riscv_pkg.sv
package riscv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [11:0] csr_addr_t;

    localparam csr_addr_t CSR_TOHOST = 12'h51e;
    localparam word_t     NOP_INSTR  = 32'h0000_0013;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
        alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
    } alu_op_e;

    typedef enum logic [2:0] {imm_i, imm_s, imm_b, imm_u, imm_j, imm_csr_z} imm_sel_e;

    typedef enum logic [1:0] {wb_load, wb_alu, wb_pc_plus_4} wb_sel_e;

    typedef enum logic [2:0] {
        br_none, br_eq, br_ne, br_lt, br_ge, br_ltu, br_geu, br_jump
    } br_type_e;

    // encoding follows funct3[1:0] of loads and stores
    typedef enum logic [1:0] {mem_byte, mem_half, mem_word} mem_size_e;

    typedef struct packed {
        alu_op_e   alu_op;
        logic      a_is_pc;
        logic      b_is_imm;
        br_type_e  br_type;
        logic      is_jalr;
        logic      mem_read;
        logic      mem_write;
        mem_size_e mem_size;
        logic      load_unsigned;
        logic      csr_write;
        logic      csr_imm;
        logic      reg_write;
        wb_sel_e   wb_sel;
    } ex_ctrl_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        word_t     pc_plus_4;
        word_t     rs1_data;
        word_t     rs2_data;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        word_t     imm;
        ex_ctrl_t  ctrl;
    } id_ex_t;

    typedef struct packed {
        logic      valid;
        word_t     alu_result;
        word_t     pc_plus_4;
        reg_addr_t rd;
        logic      reg_write;
        wb_sel_e   wb_sel;
        logic      mem_read;
        mem_size_e mem_size;
        logic      load_unsigned;
    } ex_mem_t;

    // valid already includes the register write enable
    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        word_t     data;
    } wb_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } redirect_t;

    // pick the write-back value over a stale register read
    function automatic word_t fwd_operand(reg_addr_t src, word_t data, wb_t wb);
        if (wb.valid && (wb.rd == src) && (src != 5'd0)) begin
            return wb.data;
        end
        return data;
    endfunction

endpackage

//--- verilog/riscv_alu.sv
module riscv_alu
    import riscv_pkg::*;
(
    input  word_t   a,
    input  word_t   b,
    input  alu_op_e op,
    output word_t   result,
    output logic    eq,
    output logic    lt,
    output logic    ltu
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    // comparator on the raw operand pair, shared by slt and branches
    assign eq  = (a == b);
    assign lt  = ($signed(a) < $signed(b));
    assign ltu = (a < b);

    always_comb begin
        case (op)
            alu_add: begin
                result = a + b;
            end
            alu_sub: begin
                result = a - b;
            end
            alu_sll: begin
                result = a << shamt;
            end
            alu_slt: begin
                result = {31'b0, lt};
            end
            alu_sltu: begin
                result = {31'b0, ltu};
            end
            alu_xor: begin
                result = a ^ b;
            end
            alu_srl: begin
                result = a >> shamt;
            end
            alu_sra: begin
                result = word_t'($signed(a) >>> shamt);
            end
            alu_or: begin
                result = a | b;
            end
            alu_and: begin
                result = a & b;
            end
            default: begin
                // lui passes the upper immediate through
                result = b;
            end
        endcase
    end

endmodule

//--- verilog/fetch_decode_stage.sv
module fetch_decode_stage
    import riscv_pkg::*;
#(
    parameter word_t RESET_PC       = 32'h0000_0000,
    parameter int    IMEM_ADDR_BITS = 10
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      imem_we,
    input  word_t     imem_addr,
    input  word_t     imem_data,
    input  redirect_t redirect,
    input  wb_t       wb,
    output id_ex_t    id_ex
);

    word_t    imem [2**IMEM_ADDR_BITS];
    word_t    regs [1:31];
    word_t    pc;
    word_t    next_pc;
    word_t    imem_q;
    word_t    instr;
    word_t    imm;
    imm_sel_e imm_sel;
    ex_ctrl_t ctrl;
    id_ex_t   dec;

    logic [6:0] opcode;
    logic [2:0] funct3;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    reg_addr_t  rd;
    csr_addr_t  csr_addr;

    function automatic alu_op_e alu_from_funct(logic [2:0] f3, logic alt);
        case (f3)
            3'b000:  return alt ? alu_sub : alu_add;
            3'b001:  return alu_sll;
            3'b010:  return alu_slt;
            3'b011:  return alu_sltu;
            3'b100:  return alu_xor;
            3'b101:  return alt ? alu_sra : alu_srl;
            3'b110:  return alu_or;
            default: return alu_and;
        endcase
    endfunction

    // next pc also addresses the synchronous imem read
    assign next_pc = rst ? RESET_PC : (redirect.taken ? redirect.target : pc + 32'd4);

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC;
        end else begin
            pc <= next_pc;
        end
    end

    // program load by byte address, only while held in reset
    always_ff @(posedge clk) begin
        if (rst && imem_we) begin
            imem[imem_addr[IMEM_ADDR_BITS+1:2]] <= imem_data;
        end
        imem_q <= imem[next_pc[IMEM_ADDR_BITS+1:2]];
    end

    // squashed slot decodes as a nop
    assign instr    = redirect.taken ? NOP_INSTR : imem_q;
    assign opcode   = instr[6:0];
    assign funct3   = instr[14:12];
    assign rd       = instr[11:7];
    assign rs1      = instr[19:15];
    assign rs2      = instr[24:20];
    assign csr_addr = instr[31:20];

    always_ff @(posedge clk) begin
        if (wb.valid && (wb.rd != 5'd0)) begin
            regs[wb.rd] <= wb.data;
        end
    end

    always_comb begin
        ctrl    = '0;
        imm_sel = imm_i;
        case (opcode)
            7'b0110111: begin
                ctrl.alu_op   = alu_pass_b;
                ctrl.b_is_imm = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel   = wb_alu;
                imm_sel       = imm_u;
            end
            7'b0010111: begin
                ctrl.a_is_pc   = 1'b1;
                ctrl.b_is_imm  = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = wb_alu;
                imm_sel        = imm_u;
            end
            7'b1101111, 7'b1100111: begin
                ctrl.br_type   = br_jump;
                ctrl.is_jalr   = opcode[3] == 1'b0;
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = wb_pc_plus_4;
                imm_sel        = opcode[3] ? imm_j : imm_i;
            end
            7'b1100011: begin
                ctrl.alu_op = alu_sub;
                imm_sel     = imm_b;
                case (funct3)
                    3'b000:  ctrl.br_type = br_eq;
                    3'b001:  ctrl.br_type = br_ne;
                    3'b100:  ctrl.br_type = br_lt;
                    3'b101:  ctrl.br_type = br_ge;
                    3'b110:  ctrl.br_type = br_ltu;
                    3'b111:  ctrl.br_type = br_geu;
                    default: ctrl.br_type = br_none;
                endcase
            end
            7'b0000011: begin
                ctrl.b_is_imm      = 1'b1;
                ctrl.mem_read      = 1'b1;
                ctrl.mem_size      = mem_size_e'(funct3[1:0]);
                ctrl.load_unsigned = funct3[2];
                ctrl.reg_write     = 1'b1;
                ctrl.wb_sel        = wb_load;
            end
            7'b0100011: begin
                ctrl.b_is_imm  = 1'b1;
                ctrl.mem_write = 1'b1;
                ctrl.mem_size  = mem_size_e'(funct3[1:0]);
                imm_sel        = imm_s;
            end
            7'b0010011, 7'b0110011: begin
                // bit 30 only selects sub for register ops, sra for both
                ctrl.alu_op    = alu_from_funct(funct3,
                    instr[30] && (opcode[5] || funct3 == 3'b101));
                ctrl.b_is_imm  = !opcode[5];
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = wb_alu;
            end
            7'b1110011: begin
                if (csr_addr == CSR_TOHOST && funct3[1:0] == 2'b01) begin
                    ctrl.csr_write = 1'b1;
                    ctrl.csr_imm   = funct3[2];
                    ctrl.reg_write = 1'b1;
                    ctrl.wb_sel    = wb_alu;
                    imm_sel        = imm_csr_z;
                end
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

    always_comb begin
        case (imm_sel)
            imm_s:     imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            imm_b:     imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            imm_u:     imm = {instr[31:12], 12'b0};
            imm_j:     imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            imm_csr_z: imm = {27'b0, instr[19:15]};
            default:   imm = {{20{instr[31]}}, instr[31:20]};
        endcase
    end

    always_comb begin
        dec.valid     = !redirect.taken;
        dec.pc        = pc;
        dec.pc_plus_4 = pc + 32'd4;
        // register read with bypass of this cycle's write-back
        dec.rs1_data  = fwd_operand(rs1, (rs1 == 5'd0) ? '0 : regs[rs1], wb);
        dec.rs2_data  = fwd_operand(rs2, (rs2 == 5'd0) ? '0 : regs[rs2], wb);
        dec.rs1       = rs1;
        dec.rs2       = rs2;
        dec.rd        = rd;
        dec.imm       = imm;
        dec.ctrl      = ctrl;
    end

    always_ff @(posedge clk) begin
        id_ex <= dec;
        if (rst) begin
            id_ex.valid <= 1'b0;
        end
    end

endmodule

//--- verilog/execute_stage.sv
module execute_stage
    import riscv_pkg::*;
#(
    parameter int DMEM_ADDR_BITS = 10
) (
    input  logic       clk,
    input  logic       rst,
    input  id_ex_t     id_ex,
    input  wb_t        wb,
    input  word_t      alu_result,
    input  logic       alu_eq,
    input  logic       alu_lt,
    input  logic       alu_ltu,
    output word_t      alu_a,
    output word_t      alu_b,
    output alu_op_e    alu_op,
    output redirect_t  redirect,
    output logic [3:0] dmem_we,
    output word_t      dmem_addr,
    output word_t      dmem_wdata,
    output ex_mem_t    ex_mem,
    output logic       csr_valid,
    output word_t      csr_data
);

    word_t      rs1_val;
    word_t      rs2_val;
    word_t      target;
    word_t      csr_wdata;
    logic       cond;
    logic       csr_fire;
    logic [3:0] lanes;
    ex_mem_t    ex_mem_d;

    // only the write-back stage is left to forward from
    assign rs1_val = fwd_operand(id_ex.rs1, id_ex.rs1_data, wb);
    assign rs2_val = fwd_operand(id_ex.rs2, id_ex.rs2_data, wb);

    assign alu_a  = id_ex.ctrl.a_is_pc ? id_ex.pc : rs1_val;
    assign alu_b  = id_ex.ctrl.b_is_imm ? id_ex.imm : rs2_val;
    assign alu_op = id_ex.ctrl.alu_op;

    always_comb begin
        case (id_ex.ctrl.br_type)
            br_eq:   cond = alu_eq;
            br_ne:   cond = !alu_eq;
            br_lt:   cond = alu_lt;
            br_ge:   cond = !alu_lt;
            br_ltu:  cond = alu_ltu;
            br_geu:  cond = !alu_ltu;
            br_jump: cond = 1'b1;
            default: cond = 1'b0;
        endcase
    end

    // separate target adder keeps the alu free for the compare
    assign target          = (id_ex.ctrl.is_jalr ? rs1_val : id_ex.pc) + id_ex.imm;
    assign redirect.taken  = id_ex.valid && cond;
    assign redirect.target = {target[31:1], target[0] & ~id_ex.ctrl.is_jalr};

    // store data replicated, low address bits pick the lanes
    always_comb begin
        case (id_ex.ctrl.mem_size)
            mem_byte: begin
                dmem_wdata = {4{rs2_val[7:0]}};
                lanes      = 4'b0001 << alu_result[1:0];
            end
            mem_half: begin
                dmem_wdata = {2{rs2_val[15:0]}};
                lanes      = alu_result[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                dmem_wdata = rs2_val;
                lanes      = 4'b1111;
            end
        endcase
    end

    assign dmem_we   = (id_ex.valid && id_ex.ctrl.mem_write) ? lanes : 4'b0000;
    assign dmem_addr = alu_result;

    assign csr_fire  = id_ex.valid && id_ex.ctrl.csr_write;
    assign csr_wdata = id_ex.ctrl.csr_imm ? id_ex.imm : rs1_val;

    always_ff @(posedge clk) begin
        if (rst) begin
            csr_valid <= 1'b0;
            csr_data  <= '0;
        end else begin
            csr_valid <= csr_fire;
            if (csr_fire) begin
                csr_data <= csr_wdata;
            end
        end
    end

    always_comb begin
        ex_mem_d.valid = id_ex.valid;
        // csr instructions return the old value to rd
        ex_mem_d.alu_result    = id_ex.ctrl.csr_write ? csr_data : alu_result;
        ex_mem_d.pc_plus_4     = id_ex.pc_plus_4;
        ex_mem_d.rd            = id_ex.rd;
        ex_mem_d.reg_write     = id_ex.ctrl.reg_write;
        ex_mem_d.wb_sel        = id_ex.ctrl.wb_sel;
        ex_mem_d.mem_read      = id_ex.ctrl.mem_read;
        ex_mem_d.mem_size      = id_ex.ctrl.mem_size;
        ex_mem_d.load_unsigned = id_ex.ctrl.load_unsigned;
    end

    always_ff @(posedge clk) begin
        ex_mem <= ex_mem_d;
        if (rst) begin
            ex_mem.valid <= 1'b0;
        end
    end

endmodule

//--- verilog/mem_wb_stage.sv
module mem_wb_stage
    import riscv_pkg::*;
#(
    parameter int DMEM_ADDR_BITS = 10
) (
    input  logic       clk,
    input  logic [3:0] dmem_we,
    input  word_t      dmem_addr,
    input  word_t      dmem_wdata,
    input  ex_mem_t    ex_mem,
    output wb_t        wb
);

    logic [3:0][7:0]           dmem [2**DMEM_ADDR_BITS];
    logic [3:0][7:0]           rdata;
    logic [DMEM_ADDR_BITS-1:0] idx;
    word_t                     shifted;
    word_t                     load_data;

    assign idx = dmem_addr[DMEM_ADDR_BITS+1:2];

    // byte lanes written separately, read data lands one cycle later
    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (dmem_we[i]) begin
                dmem[idx][i] <= dmem_wdata[8*i +: 8];
            end
        end
        rdata <= dmem[idx];
    end

    // registered offset moves the addressed lane down
    assign shifted = rdata >> {ex_mem.alu_result[1:0], 3'b000};

    always_comb begin
        case (ex_mem.mem_size)
            mem_byte: begin
                if (ex_mem.load_unsigned) begin
                    load_data = {24'b0, shifted[7:0]};
                end else begin
                    load_data = {{24{shifted[7]}}, shifted[7:0]};
                end
            end
            mem_half: begin
                if (ex_mem.load_unsigned) begin
                    load_data = {16'b0, shifted[15:0]};
                end else begin
                    load_data = {{16{shifted[15]}}, shifted[15:0]};
                end
            end
            default: begin
                load_data = rdata;
            end
        endcase
    end

    always_comb begin
        wb.valid = ex_mem.valid && ex_mem.reg_write;
        wb.rd    = ex_mem.rd;
        if (ex_mem.mem_read) begin
            wb.data = load_data;
        end else if (ex_mem.wb_sel == wb_pc_plus_4) begin
            wb.data = ex_mem.pc_plus_4;
        end else begin
            wb.data = ex_mem.alu_result;
        end
    end

endmodule

//--- verilog/riscv_core.sv
module riscv_core
    import riscv_pkg::*;
#(
    parameter word_t RESET_PC       = 32'h0000_0000,
    parameter int    IMEM_ADDR_BITS = 10,
    parameter int    DMEM_ADDR_BITS = 10
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  imem_we,
    input  word_t imem_addr,
    input  word_t imem_data,
    output logic  csr_valid,
    output word_t csr_data
);

    id_ex_t     id_ex;
    ex_mem_t    ex_mem;
    wb_t        wb;
    redirect_t  redirect;
    word_t      alu_a;
    word_t      alu_b;
    word_t      alu_result;
    alu_op_e    alu_op;
    logic       alu_eq;
    logic       alu_lt;
    logic       alu_ltu;
    logic [3:0] dmem_we;
    word_t      dmem_addr;
    word_t      dmem_wdata;

    fetch_decode_stage #(
        .RESET_PC      (RESET_PC),
        .IMEM_ADDR_BITS(IMEM_ADDR_BITS)
    ) i_fetch_decode_stage (
        .clk      (clk),
        .rst      (rst),
        .imem_we  (imem_we),
        .imem_addr(imem_addr),
        .imem_data(imem_data),
        .redirect (redirect),
        .wb       (wb),
        .id_ex    (id_ex)
    );

    execute_stage #(
        .DMEM_ADDR_BITS(DMEM_ADDR_BITS)
    ) i_execute_stage (
        .clk       (clk),
        .rst       (rst),
        .id_ex     (id_ex),
        .wb        (wb),
        .alu_result(alu_result),
        .alu_eq    (alu_eq),
        .alu_lt    (alu_lt),
        .alu_ltu   (alu_ltu),
        .alu_a     (alu_a),
        .alu_b     (alu_b),
        .alu_op    (alu_op),
        .redirect  (redirect),
        .dmem_we   (dmem_we),
        .dmem_addr (dmem_addr),
        .dmem_wdata(dmem_wdata),
        .ex_mem    (ex_mem),
        .csr_valid (csr_valid),
        .csr_data  (csr_data)
    );

    riscv_alu i_riscv_alu (
        .a     (alu_a),
        .b     (alu_b),
        .op    (alu_op),
        .result(alu_result),
        .eq    (alu_eq),
        .lt    (alu_lt),
        .ltu   (alu_ltu)
    );

    mem_wb_stage #(
        .DMEM_ADDR_BITS(DMEM_ADDR_BITS)
    ) i_mem_wb_stage (
        .clk       (clk),
        .dmem_we   (dmem_we),
        .dmem_addr (dmem_addr),
        .dmem_wdata(dmem_wdata),
        .ex_mem    (ex_mem),
        .wb        (wb)
    );

endmodule

//--- sim/riscv_core_assert.sv
module riscv_core_assert
    import riscv_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input id_ex_t     id_ex,
    input redirect_t  redirect,
    input logic [3:0] dmem_we,
    input logic       csr_valid
);
    timeunit 1ns;
    timeprecision 1ps;

    // one write pulse per csr instruction
    a_csr_single_pulse: assert property (@(posedge clk) disable iff (rst)
        csr_valid |=> !csr_valid)
        else $error("csr_valid held high for two cycles");

    // younger instruction must become a bubble
    a_flush_after_redirect: assert property (@(posedge clk) disable iff (rst)
        redirect.taken |=> !id_ex.valid)
        else $error("id_ex still valid after a taken redirect");

    a_no_store_from_bubble: assert property (@(posedge clk) disable iff (rst)
        !id_ex.valid |-> (dmem_we == 4'b0000))
        else $error("store enable asserted by an invalid id_ex");

endmodule

bind execute_stage riscv_core_assert i_riscv_core_assert (.*);

//--- sim/riscv_core_tb.sv
module riscv_core_tb
    import riscv_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam word_t       SELF_JUMP = 32'h0000_006f;
    localparam logic [11:0] REGION    = 12'h200;

    logic  clk = 1'b0;
    logic  rst;
    logic  imem_we;
    word_t imem_addr;
    word_t imem_data;
    logic  csr_valid;
    word_t csr_data;

    logic [31:0] lfsr;
    word_t       prog [256];
    int          n_words;
    word_t       exp_q[$];
    int          value_errors = 0;
    int          other_errors = 0;
    logic        seen_csr = 1'b0;

    riscv_core i_riscv_core (
        .clk      (clk),
        .rst      (rst),
        .imem_we  (imem_we),
        .imem_addr(imem_addr),
        .imem_data(imem_data),
        .csr_valid(csr_valid),
        .csr_data (csr_data)
    );

    always #5 clk = ~clk;

    function automatic logic lfsr_bit();
        logic lsb;
        lsb  = lfsr[0];
        lfsr = lfsr >> 1;
        if (lsb) begin
            lfsr = lfsr ^ 32'hA300_0000;
        end
        return lsb;
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    // x1..x7 are the scratch registers
    function automatic logic [4:0] rand_reg();
        return 5'(rand_bits(3) % 7 + 1);
    endfunction

    function automatic word_t enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                    logic [4:0] rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                    logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                    logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic word_t enc_j(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic void emit(word_t w);
        prog[n_words] = w;
        n_words++;
    endfunction

    // csrrw or csrrwi to tohost, old value lands in x9
    function automatic void emit_csr(logic [4:0] src);
        if (rand_bits(2) == 0) begin
            emit(enc_i(CSR_TOHOST, 5'(rand_bits(5)), 3'b101, 5'd9, 7'b1110011));
        end else begin
            emit(enc_i(CSR_TOHOST, src, 3'b001, 5'd9, 7'b1110011));
        end
    endfunction

    function automatic void emit_load();
        logic [1:0]  size;
        logic        uns;
        logic [11:0] off;
        logic [4:0]  rd;
        size = 2'(rand_bits(2) % 3);
        uns  = (size == 2'd2) ? 1'b0 : 1'(rand_bits(1));
        off  = 12'(rand_bits(6)) & ~12'((1 << size) - 1);
        rd   = rand_reg();
        emit(enc_i(off, 5'd8, {uns, size}, rd, 7'b0000011));
        emit_csr(rd);
    endfunction

    task automatic build_program();
        logic [2:0]  kind;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [4:0]  rs2;
        logic [11:0] imm;
        logic [1:0]  size;
        int          k;
        n_words = 0;
        for (int r = 1; r <= 7; r++) begin
            emit(enc_i(12'(rand_bits(12)), 5'd0, 3'b000, 5'(r), 7'b0010011));
        end
        emit(enc_i(REGION, 5'd0, 3'b000, 5'd8, 7'b0010011));
        emit(enc_i(12'd0, 5'd0, 3'b000, 5'd9, 7'b0010011));
        // fill the data region so every load sees defined bytes
        for (int w = 0; w < 16; w++) begin
            emit(enc_s(12'(w * 4), rand_reg(), 5'd8, 3'b010));
        end
        while (n_words < 190) begin
            kind = 3'(rand_bits(3));
            rd   = rand_reg();
            case (kind)
                3'd0, 3'd1: begin
                    f3  = 3'(rand_bits(3));
                    imm = 12'(rand_bits(12));
                    if (f3 == 3'b001) begin
                        imm = {7'b0, imm[4:0]};
                    end else if (f3 == 3'b101) begin
                        imm = {1'b0, imm[10], 5'b0, imm[4:0]};
                    end
                    emit(enc_i(imm, rand_reg(), f3, rd, 7'b0010011));
                    emit_csr(rd);
                end
                3'd2: begin
                    f3  = 3'(rand_bits(3));
                    rs2 = rand_bits(1) ? 5'd9 : rand_reg();
                    imm = ((f3 == 3'b000 || f3 == 3'b101) && rand_bits(1)) ? 12'h400 : 12'h0;
                    emit(enc_i(imm | 12'(rs2), rand_reg(), f3, rd, 7'b0110011));
                    emit_csr(rd);
                end
                3'd3: begin
                    emit({20'(rand_bits(20)), rd, rand_bits(1) ? 7'b0110111 : 7'b0010111});
                    emit_csr(rd);
                end
                3'd4: begin
                    size = 2'(rand_bits(2) % 3);
                    imm  = 12'(rand_bits(6)) & ~12'((1 << size) - 1);
                    emit(enc_s(imm, rand_reg(), 5'd8, {1'b0, size}));
                    emit_load();
                end
                3'd5: begin
                    emit_load();
                end
                3'd6: begin
                    do begin
                        f3 = 3'(rand_bits(3));
                    end while (f3 == 3'b010 || f3 == 3'b011);
                    k = int'(rand_bits(2) % 3) + 1;
                    emit(enc_b(13'((k + 1) * 4), rand_reg(), rand_reg(), f3));
                    // skipped slots alternate so csr writes never touch
                    for (int j = 0; j < k; j++) begin
                        if (j % 2 == 0) begin
                            emit(enc_i(CSR_TOHOST, 5'(rand_bits(5)), 3'b101, 5'd9,
                                       7'b1110011));
                        end else begin
                            emit(enc_i(12'(rand_bits(12)), rand_reg(), 3'b000, rand_reg(),
                                       7'b0010011));
                        end
                    end
                end
                default: begin
                    k = int'(rand_bits(2) % 3) + 1;
                    if (rand_bits(1)) begin
                        emit(enc_j(21'((k + 1) * 4), rd));
                    end else begin
                        emit({20'd0, 5'd7, 7'b0010111});
                        emit(enc_i(12'(8 + 4 * k + rand_bits(1)), 5'd7, 3'b000, rd,
                                   7'b1100111));
                    end
                    for (int j = 0; j < k; j++) begin
                        emit(enc_i(CSR_TOHOST, 5'(rand_bits(5)), 3'b101, 5'd9, 7'b1110011));
                    end
                    emit_csr(rd);
                end
            endcase
        end
        emit(SELF_JUMP);
    endtask

    // instruction-set model, queues every expected csr value
    task automatic run_model();
        word_t      x [32];
        logic [7:0] dm [4096];
        word_t      pc;
        word_t      npc;
        word_t      ins;
        word_t      a;
        word_t      b;
        word_t      addr;
        word_t      ld;
        word_t      csr;
        word_t      imm_i;
        word_t      imm_s;
        word_t      imm_b;
        logic       take;
        logic [2:0] f3;
        logic [4:0] rd;
        foreach (x[i]) x[i] = '0;
        foreach (dm[i]) dm[i] = '0;
        pc  = '0;
        csr = '0;
        for (int step = 0; step < 5000; step++) begin
            ins = prog[pc[9:2]];
            if (ins == SELF_JUMP) begin
                break;
            end
            f3    = ins[14:12];
            rd    = ins[11:7];
            a     = x[ins[19:15]];
            b     = x[ins[24:20]];
            imm_i = {{20{ins[31]}}, ins[31:20]};
            imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            npc   = pc + 4;
            case (ins[6:0])
                7'b0110111: x[rd] = {ins[31:12], 12'b0};
                7'b0010111: x[rd] = pc + {ins[31:12], 12'b0};
                7'b1101111: begin
                    x[rd] = pc + 4;
                    npc   = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
                end
                7'b1100111: begin
                    npc   = (a + imm_i) & ~32'd1;
                    x[rd] = pc + 4;
                end
                7'b1100011: begin
                    case (f3)
                        3'b000:  take = (a == b);
                        3'b001:  take = (a != b);
                        3'b100:  take = ($signed(a) < $signed(b));
                        3'b101:  take = ($signed(a) >= $signed(b));
                        3'b110:  take = (a < b);
                        default: take = (a >= b);
                    endcase
                    if (take) begin
                        npc = pc + imm_b;
                    end
                end
                7'b0000011: begin
                    addr = a + imm_i;
                    ld   = {dm[addr[11:0] + 3], dm[addr[11:0] + 2],
                            dm[addr[11:0] + 1], dm[addr[11:0]]};
                    case (f3)
                        3'b000:  x[rd] = {{24{ld[7]}}, ld[7:0]};
                        3'b001:  x[rd] = {{16{ld[15]}}, ld[15:0]};
                        3'b100:  x[rd] = {24'b0, ld[7:0]};
                        3'b101:  x[rd] = {16'b0, ld[15:0]};
                        default: x[rd] = ld;
                    endcase
                end
                7'b0100011: begin
                    addr = a + imm_s;
                    for (int i = 0; i < (1 << f3[1:0]); i++) begin
                        dm[addr[11:0] + i] = b[8*i +: 8];
                    end
                end
                7'b0010011, 7'b0110011: begin
                    if (ins[5] == 1'b0) begin
                        b = imm_i;
                    end
                    case (f3)
                        3'b000: x[rd] = (ins[5] && ins[30]) ? a - b : a + b;
                        3'b001: x[rd] = a << b[4:0];
                        3'b010: x[rd] = word_t'($signed(a) < $signed(b));
                        3'b011: x[rd] = word_t'(a < b);
                        3'b100: x[rd] = a ^ b;
                        3'b101: x[rd] = ins[30] ? word_t'($signed(a) >>> b[4:0])
                                                : a >> b[4:0];
                        3'b110: x[rd] = a | b;
                        default: x[rd] = a & b;
                    endcase
                end
                default: begin
                    x[rd] = csr;
                    csr   = f3[2] ? {27'b0, ins[19:15]} : a;
                    exp_q.push_back(csr);
                end
            endcase
            x[0] = '0;
            pc   = npc;
        end
    endtask

    task automatic check_word(string name, word_t got, word_t expected);
        if (got !== expected) begin
            $display("ERROR at %0t: %s got %h expected %h", $time, name, got, expected);
            value_errors++;
        end
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            if (csr_valid) begin
                seen_csr <= 1'b1;
                if (exp_q.size() == 0) begin
                    $display("unexpected CSR write of %h at %0t", csr_data, $time);
                    other_errors++;
                end else begin
                    check_word("csr_data", csr_data, exp_q.pop_front());
                end
            end else if (!seen_csr) begin
                check_word("csr_data", csr_data, '0);
            end
        end
    end

    initial begin
        int cycles;
        rst       = 1'b1;
        imem_we   = 1'b0;
        imem_addr = '0;
        imem_data = '0;
        lfsr      = 32'd77;
        build_program();
        run_model();
        for (int i = 0; i < n_words; i++) begin
            @(posedge clk);
            imem_we   <= 1'b1;
            imem_addr <= word_t'(i * 4);
            imem_data <= prog[i];
        end
        @(posedge clk);
        imem_we <= 1'b0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        cycles = 0;
        while (exp_q.size() > 0 && cycles < 20000) begin
            @(posedge clk);
            cycles++;
        end
        if (exp_q.size() > 0) begin
            $display("timeout: core hung with %0d CSR writes still expected", exp_q.size());
            other_errors++;
        end
        // idle a little so stray csr pulses get caught
        for (int i = 0; i < 20; i++) begin
            @(posedge clk);
        end
        $display("errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- riscv_core.f
verilog/riscv_pkg.sv
verilog/riscv_alu.sv
verilog/fetch_decode_stage.sv
verilog/execute_stage.sv
verilog/mem_wb_stage.sv
verilog/riscv_core.sv
sim/riscv_core_assert.sv
sim/riscv_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := riscv_core_tb
FILELIST  := riscv_core.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(shell grep -v '^+' $(FILELIST))
PASS_MSG  := Simulation completed successfully

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
